// File: bench/usb_rx_tb.sv
`timescale 1ns/1ns
module usb_rx_tb;

  import ulpi_pkg::*;
  import usb_pkg::*;

  `include "usb_crc.svh"

  localparam int NUM_TESTS  = 18;
  localparam int MAX_CYCLES = 64 * NUM_TESTS + 50;
  localparam logic [31:0] SEED = 32'h0ee25ffc;
  localparam logic [6:0] DEV_ADDR = 7'h2a;

  localparam logic [1:0] K_TOK  = 2'd0;
  localparam logic [1:0] K_DATA = 2'd1;
  localparam logic [1:0] K_HSK  = 2'd2;

  localparam logic [3:0] PID_OUT   = {TOK_OUT, PID_TOKEN};
  localparam logic [3:0] PID_IN    = {TOK_IN, PID_TOKEN};
  localparam logic [3:0] PID_SOF   = {TOK_SOF, PID_TOKEN};
  localparam logic [3:0] PID_SETUP = {TOK_SETUP, PID_TOKEN};
  localparam logic [3:0] PID_DATA0 = {2'b00, PID_DATA};
  localparam logic [3:0] PID_DATA1 = {2'b10, PID_DATA};
  localparam logic [3:0] PID_ACK   = {2'b00, PID_HANDSHAKE};

  // RX_CMD with RxActive set, sent before the PID and in the nxt gap
  localparam logic [7:0] RXCMD_BYTE = {2'b00, RXCMD_ACTIVE, 4'h0};

  // One table entry, hit is the expected outcome
  typedef struct packed {
    logic [1:0]  kind;
    logic [3:0]  pid;
    logic [10:0] word;
    logic [3:0]  len;
    logic        corrupt;
    logic        en;
    logic        hit;
  } test_t;

  logic        clock;
  logic        reset;
  ulpi_bus_t   ulpi;
  logic [6:0]  dev_addr;
  logic        dev_enable;
  usb_stream_t data;
  token_evt_t  tok;
  logic        sof_valid;
  logic [10:0] sof_frame;
  logic        crc_error;
  logic        crc_valid;

  test_t       tests [NUM_TESTS];
  usb_stream_t beats[$];
  token_evt_t  toks[$];
  logic [10:0] frames[$];
  logic        crc_errs[$];
  logic [7:0]  payload[$];
  logic [7:0]  bytes[$];
  logic [31:0] rng;
  int          cycles = 0;

  usb_rx_top usb_rx_top_i (
    .clock        (clock),
    .reset        (reset),
    .ulpi_i       (ulpi),
    .dev_addr_i   (dev_addr),
    .dev_enable_i (dev_enable),
    .data_o       (data),
    .tok_o        (tok),
    .sof_valid_o  (sof_valid),
    .sof_frame_o  (sof_frame),
    .crc_error_o  (crc_error),
    .crc_valid_o  (crc_valid)
  );

  initial clock = 1'b0;
  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("Checks failed");
      $fatal(1, "Run timed out after %0d cycles without finishing the table", cycles);
    end
  end

  // Output monitors
  always @(posedge clock) begin
    if (!reset) begin
      if (data.valid) begin
        beats.push_back(data);
      end
      if (tok.valid) begin
        toks.push_back(tok);
      end
      if (sof_valid) begin
        frames.push_back(sof_frame);
      end
      if (crc_valid) begin
        crc_errs.push_back(crc_error);
      end
    end
  end

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic test_t make_test(input logic [1:0] kind, input logic [3:0] pid,
                                      input logic [10:0] word, input logic [3:0] len,
                                      input logic corrupt, input logic en, input logic hit);
    test_t t;
    t.kind    = kind;
    t.pid     = pid;
    t.word    = word;
    t.len     = len;
    t.corrupt = corrupt;
    t.en      = en;
    t.hit     = hit;
    return t;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic load_tests();
    // Token word is {endp, addr} or an SOF frame number
    tests[0]  = make_test(K_TOK, PID_OUT, {4'd1, DEV_ADDR}, 4'd0, 1'b0, 1'b1, 1'b1);
    tests[1]  = make_test(K_DATA, PID_DATA0, 11'd0, 4'd5, 1'b0, 1'b1, 1'b1);
    tests[2]  = make_test(K_TOK, PID_SETUP, {4'd0, DEV_ADDR}, 4'd0, 1'b0, 1'b1, 1'b1);
    tests[3]  = make_test(K_DATA, PID_DATA0, 11'd0, 4'd8, 1'b0, 1'b1, 1'b1);
    tests[4]  = make_test(K_TOK, PID_OUT, {4'd1, 7'h15}, 4'd0, 1'b0, 1'b1, 1'b0);
    tests[5]  = make_test(K_DATA, PID_DATA1, 11'd0, 4'd4, 1'b0, 1'b1, 1'b0);
    // Device disabled
    tests[6]  = make_test(K_TOK, PID_OUT, {4'd1, DEV_ADDR}, 4'd0, 1'b0, 1'b0, 1'b0);
    tests[7]  = make_test(K_DATA, PID_DATA1, 11'd0, 4'd3, 1'b0, 1'b0, 1'b0);
    tests[8]  = make_test(K_TOK, PID_OUT, {4'd3, DEV_ADDR}, 4'd0, 1'b0, 1'b1, 1'b1);
    tests[9]  = make_test(K_DATA, PID_DATA1, 11'd0, 4'd6, 1'b1, 1'b1, 1'b1);
    tests[10] = make_test(K_TOK, PID_IN, {4'd2, DEV_ADDR}, 4'd0, 1'b0, 1'b1, 1'b1);
    tests[11] = make_test(K_HSK, PID_ACK, 11'd0, 4'd0, 1'b0, 1'b1, 1'b1);
    tests[12] = make_test(K_TOK, PID_SOF, 11'h5c3, 4'd0, 1'b0, 1'b1, 1'b1);
    tests[13] = make_test(K_TOK, PID_SOF, 11'h0d1, 4'd0, 1'b1, 1'b1, 1'b0);
    tests[14] = make_test(K_TOK, PID_OUT, {4'd1, DEV_ADDR}, 4'd0, 1'b1, 1'b1, 1'b0);
    tests[15] = make_test(K_DATA, PID_DATA0, 11'd0, 4'd2, 1'b0, 1'b1, 1'b0);
    tests[16] = make_test(K_TOK, PID_OUT, {4'd4, DEV_ADDR}, 4'd0, 1'b0, 1'b1, 1'b1);
    tests[17] = make_test(K_DATA, PID_DATA1, 11'd0, 4'd0, 1'b0, 1'b1, 1'b1);
  endtask

  task automatic drive_bus(input logic dir, input logic nxt, input logic [7:0] d);
    @(posedge clock);
    #2;
    ulpi.dir  = dir;
    ulpi.nxt  = nxt;
    ulpi.data = d;
  endtask

  // Wire bytes of one packet, PID first, CRC field low byte first
  task automatic build_packet(input test_t t);
    logic [15:0] c;
    logic [15:0] f;
    logic [7:0]  b2;
    bytes.delete();
    payload.delete();
    bytes.push_back({~t.pid, t.pid});
    if (t.kind == K_TOK) begin
      b2 = {crc5(t.word), t.word[10:8]};
      if (t.corrupt) begin
        b2 = b2 ^ 8'h08;
      end
      bytes.push_back(t.word[7:0]);
      bytes.push_back(b2);
    end else if (t.kind == K_DATA) begin
      c = 16'hffff;
      for (int i = 0; i < t.len; i++) begin
        rng = next_rand(rng);
        payload.push_back(rng[7:0]);
        bytes.push_back(rng[7:0]);
        c = crc16(rng[7:0], c);
      end
      for (int i = 0; i < 16; i++) begin
        f[i] = ~c[15 - i];
      end
      if (t.corrupt) begin
        f[4] = ~f[4];
      end
      bytes.push_back(f[7:0]);
      bytes.push_back(f[15:8]);
    end
  endtask

  // Turnaround, RX_CMD, bytes with one nxt gap, then RxActive dropped
  task automatic send_packet();
    int gap;
    gap = bytes.size() / 2;
    drive_bus(1'b1, 1'b0, 8'h00);
    drive_bus(1'b1, 1'b0, RXCMD_BYTE);
    for (int i = 0; i < bytes.size(); i++) begin
      if (i == gap) begin
        drive_bus(1'b1, 1'b0, RXCMD_BYTE);
      end
      drive_bus(1'b1, 1'b1, bytes[i]);
    end
    drive_bus(1'b1, 1'b0, 8'h00);
    drive_bus(1'b0, 1'b0, 8'h00);
  endtask

  task automatic check_beats(input test_t t);
    for (int i = 0; i < t.len; i++) begin
      check_value(beats[i].data, payload[i], "payload byte");
      check_value(beats[i].keep, 1, "keep on payload beat");
      check_value(beats[i].last, 0, "last on payload beat");
      check_value(beats[i].pid, t.pid, "pid on payload beat");
    end
    check_value(beats[t.len].last, 1, "last on closing beat");
    check_value(beats[t.len].keep, 0, "keep on closing beat");
    check_value(beats[t.len].pid, t.pid, "pid on closing beat");
  endtask

  task automatic check_results(input test_t t);
    if (t.kind == K_HSK) begin
      check_value(crc_errs.size(), 0, "CRC pulses on handshake");
      check_value(beats.size(), t.hit ? 1 : 0, "handshake beat count");
      if (t.hit) begin
        check_beats(t);
      end
    end else begin
      check_value(crc_errs.size(), 1, "CRC pulse count");
      check_value(crc_errs[0], t.corrupt, "CRC error flag");
    end
    if (t.kind == K_DATA) begin
      check_value(beats.size(), t.hit ? int'(t.len) + 1 : 0, "data beat count");
      if (t.hit) begin
        check_beats(t);
      end
    end
    if (t.kind == K_TOK) begin
      check_value(beats.size(), 0, "data beats after token");
      if (t.pid == PID_SOF) begin
        check_value(frames.size(), t.hit, "SOF pulse count");
        check_value(toks.size(), 0, "token events on SOF");
        if (t.hit) begin
          check_value(frames[0], t.word, "SOF frame number");
        end
      end else begin
        check_value(toks.size(), t.hit, "token event count");
        check_value(frames.size(), 0, "SOF pulses on token");
        if (t.hit) begin
          check_value(toks[0].pid, t.pid, "token pid");
          check_value(toks[0].payload.dev.addr, t.word[6:0], "token address");
          check_value(toks[0].payload.dev.endp, t.word[10:7], "token endpoint");
          check_value(toks[0].crc_ok, 1, "token crc_ok");
        end
      end
    end
  endtask

  initial begin
    test_t t;
    ulpi       = '0;
    dev_addr   = DEV_ADDR;
    dev_enable = 1'b0;
    reset      = 1'b1;
    rng        = SEED;
    load_tests();
    repeat (2) @(posedge clock);
    #2;
    reset = 1'b0;
    for (int n = 0; n < NUM_TESTS; n++) begin
      t = tests[n];
      @(posedge clock);
      #2;
      dev_enable = t.en;
      beats.delete();
      toks.delete();
      frames.delete();
      crc_errs.delete();
      build_packet(t);
      send_packet();
      // Decoder reports its CRC check, handshakes only show up on data_o
      if (t.kind != K_HSK) begin
        while (crc_errs.size() == 0) @(posedge clock);
        repeat (4) @(posedge clock);
      end else if (t.hit) begin
        while (beats.size() == 0) @(posedge clock);
        repeat (4) @(posedge clock);
      end else begin
        repeat (8) @(posedge clock);
      end
      check_results(t);
    end
    $display("All checks passed");
    $finish;
  end

endmodule

// File: common/ulpi_pkg.sv
package ulpi_pkg;

  // RxEvent field of an RX_CMD byte, bits 5:4
  localparam logic [1:0] RXCMD_ACTIVE = 2'b01;
  localparam logic [1:0] RXCMD_ERROR  = 2'b11;

  // ULPI bus as seen by the link on one clock edge
  typedef struct packed {
    // PHY owns the data bus when high
    logic       dir;
    // PHY strobe, marks a received byte while dir is high
    logic       nxt;
    // Packet byte when nxt is high, RX_CMD when nxt is low
    logic [7:0] data;
  } ulpi_bus_t;

endpackage

// File: common/usb_crc.svh
// CRC5 over the token payload, bit 0 first as sent on the wire
// Result is inverted and bit reversed so it lines up with bits 7:3 of the second token byte
function automatic logic [4:0] crc5(input logic [10:0] d);
  logic [4:0] c;
  logic       fb;
  c = 5'h1f;
  for (int i = 0; i < 11; i++) begin
    fb = c[4] ^ d[i];
    c  = {c[3:0], 1'b0} ^ (fb ? 5'h05 : 5'h00);
  end
  return ~{c[0], c[1], c[2], c[3], c[4]};
endfunction

// One byte step of CRC16 with polynomial 8005, data bit 0 first
// Start from 16'hffff; a good packet including its CRC field ends at CRC16_RESIDUAL
// The transmitted field is the inverted, bit reversed register, low byte first
function automatic logic [15:0] crc16(input logic [7:0] d, input logic [15:0] s);
  logic [15:0] c;
  logic        fb;
  c = s;
  for (int i = 0; i < 8; i++) begin
    fb = c[15] ^ d[i];
    c  = {c[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
  end
  return c;
endfunction

// File: common/usb_pkg.sv
package usb_pkg;

  // PID type, bits 1:0 of the PID
  localparam logic [1:0] PID_SPECIAL   = 2'b00;
  localparam logic [1:0] PID_TOKEN     = 2'b01;
  localparam logic [1:0] PID_HANDSHAKE = 2'b10;
  localparam logic [1:0] PID_DATA      = 2'b11;

  // Token subtypes, bits 3:2 of a token PID
  localparam logic [1:0] TOK_OUT   = 2'b00;
  localparam logic [1:0] TOK_SOF   = 2'b01;
  localparam logic [1:0] TOK_IN    = 2'b10;
  localparam logic [1:0] TOK_SETUP = 2'b11;

  // PING is a special PID but carries a token payload
  localparam logic [1:0] SPC_PING = 2'b01;

  // Left in the CRC16 register after a packet with a good CRC field
  localparam logic [15:0] CRC16_RESIDUAL = 16'h800d;

  // Address view of a token payload
  typedef struct packed {
    logic [3:0] endp;
    logic [6:0] addr;
  } token_dev_t;

  // The 11 payload bits of a token, read as device and endpoint or as an SOF frame
  typedef union packed {
    token_dev_t  dev;
    logic [10:0] frame;
  } token_u;

  // One beat of a received packet, PID and CRC bytes already stripped
  typedef struct packed {
    logic       valid;
    // Low on the closing beat, which holds no payload
    logic       keep;
    logic       last;
    logic [3:0] pid;
    logic [7:0] data;
  } usb_stream_t;

  // One received token
  typedef struct packed {
    logic       valid;
    logic       crc_ok;
    logic [3:0] pid;
    token_u     payload;
  } token_evt_t;

endpackage

// File: logic/usb_rx_top.sv
`timescale 1ns/1ns
module usb_rx_top (
  input  logic                 clock,
  input  logic                 reset,
  input  ulpi_pkg::ulpi_bus_t  ulpi_i,
  input  logic [6:0]           dev_addr_i,
  input  logic                 dev_enable_i,
  output usb_pkg::usb_stream_t data_o,
  output usb_pkg::token_evt_t  tok_o,
  output logic                 sof_valid_o,
  output logic [10:0]          sof_frame_o,
  output logic                 crc_error_o,
  output logic                 crc_valid_o
);

  import usb_pkg::*;

  // Decoder to filter
  usb_stream_t pkt;
  token_evt_t  tok;

  ulpi_decoder ulpi_decoder_i (
    .clock       (clock),
    .reset       (reset),
    .ulpi_bus_i  (ulpi_i),
    .pkt_o       (pkt),
    .tok_o       (tok),
    .crc_error_o (crc_error_o),
    .crc_valid_o (crc_valid_o)
  );

  usb_token_filter usb_token_filter_i (
    .clock        (clock),
    .reset        (reset),
    .dev_addr_i   (dev_addr_i),
    .dev_enable_i (dev_enable_i),
    .pkt_i        (pkt),
    .tok_i        (tok),
    .data_o       (data_o),
    .tok_o        (tok_o),
    .sof_valid_o  (sof_valid_o),
    .sof_frame_o  (sof_frame_o)
  );

endmodule

// File: logic/usb_token_filter.sv
`timescale 1ns/1ns
module usb_token_filter (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [6:0]           dev_addr_i,
  input  logic                 dev_enable_i,
  input  usb_pkg::usb_stream_t pkt_i,
  input  usb_pkg::token_evt_t  tok_i,
  output usb_pkg::usb_stream_t data_o,
  output usb_pkg::token_evt_t  tok_o,
  output logic                 sof_valid_o,
  output logic [10:0]          sof_frame_o
);

  import usb_pkg::*;

  logic        window_q;
  logic        is_sof_w;
  logic        is_dev_tok_w;
  logic        addr_hit_w;
  logic        data_kind_w;
  logic        pass_w;
  logic        data_vld_q;
  logic        tok_vld_q;
  usb_stream_t data_q;
  token_evt_t  tok_q;

  always_comb begin
    is_sof_w     = 1'b0;
    is_dev_tok_w = 1'b0;
    if (tok_i.pid[1:0] == PID_TOKEN) begin
      case (tok_i.pid[3:2])
        TOK_SOF: begin
          is_sof_w = 1'b1;
        end
        TOK_OUT, TOK_IN, TOK_SETUP: begin
          is_dev_tok_w = 1'b1;
        end
      endcase
    end else if (tok_i.pid == {SPC_PING, PID_SPECIAL}) begin
      is_dev_tok_w = 1'b1;
    end
  end

  // SOF reads the payload as a frame number, every other token as address and endpoint
  assign addr_hit_w = dev_enable_i && tok_i.crc_ok && is_dev_tok_w &&
                      tok_i.payload.dev.addr == dev_addr_i;

  assign data_kind_w = pkt_i.pid[1:0] == PID_DATA || pkt_i.pid[1:0] == PID_HANDSHAKE;
  assign pass_w      = pkt_i.valid && window_q && dev_enable_i && data_kind_w;

  always_ff @(posedge clock) begin
    if (reset) begin
      window_q    <= 1'b0;
      data_vld_q  <= 1'b0;
      tok_vld_q   <= 1'b0;
      sof_valid_o <= 1'b0;
    end else begin
      data_vld_q  <= pass_w;
      tok_vld_q   <= tok_i.valid && addr_hit_w;
      sof_valid_o <= tok_i.valid && is_sof_w && tok_i.crc_ok;
      // Every token decides afresh, the end of a forwarded packet closes the window
      if (tok_i.valid) begin
        window_q <= addr_hit_w;
      end else if (pass_w && pkt_i.last) begin
        window_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    data_q <= pkt_i;
    tok_q  <= tok_i;
    if (tok_i.valid && is_sof_w && tok_i.crc_ok) begin
      sof_frame_o <= tok_i.payload.frame;
    end
  end

  assign data_o = '{
    valid: data_vld_q,
    keep:  data_q.keep,
    last:  data_q.last,
    pid:   data_q.pid,
    data:  data_q.data
  };

  assign tok_o = '{
    valid:   tok_vld_q,
    crc_ok:  tok_q.crc_ok,
    pid:     tok_q.pid,
    payload: tok_q.payload
  };

endmodule

// File: ulpi_decoder/ulpi_decoder.sv
`timescale 1ns/1ns
module ulpi_decoder (
  input  logic                 clock,
  input  logic                 reset,
  input  ulpi_pkg::ulpi_bus_t  ulpi_bus_i,
  output usb_pkg::usb_stream_t pkt_o,
  output usb_pkg::token_evt_t  tok_o,
  output logic                 crc_error_o,
  output logic                 crc_valid_o
);

  import ulpi_pkg::*;
  import usb_pkg::*;

  `include "usb_crc.svh"

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_PID,
    RX_DATA,
    RX_LAST,
    RX_DONE
  } rx_state_t;

  // Bus registers
  ulpi_bus_t   ulpi_q;
  logic        dir_q;

  // Packet framing on the registered bus
  logic        in_pkt_q;
  logic        rx_err_q;
  logic [1:0]  nbytes_q;
  logic        pid_w;
  logic        byte_w;
  logic        eop_w;
  logic        rxerr_w;
  logic        pid_ok_w;

  // Alignment stage
  logic        pid_stb_q;
  logic        byte_stb_q;
  logic        eop_stb_q;
  logic        pid_ok_q;
  logic [3:0]  pid_q;
  logic [7:0]  byte_q;

  // Token capture and CRC state
  token_u      token_q;
  logic [4:0]  crc5_q;
  logic [15:0] crc16_q;
  logic        tok_crc_ok_w;
  logic        crc_bad_w;
  logic        check_w;

  // Packet kind, latched with the PID
  logic        is_tok_w;
  logic        is_hsk_w;
  logic        is_dat_w;
  logic [3:0]  cur_pid_q;
  logic        kind_tok_q;
  logic        kind_dat_q;

  // Output FSM and CRC16 strip buffer
  rx_state_t   state_q;
  logic        start_w;
  logic        push_w;
  logic        emit_byte_w;
  logic        emit_last_w;
  logic [7:0]  hold0_q;
  logic [7:0]  hold1_q;
  logic [1:0]  hold_cnt_q;
  logic        pkt_vld_q;
  logic        pkt_last_q;
  logic [7:0]  pkt_data_q;
  logic        tok_vld_q;
  logic        tok_ok_q;

  always_ff @(posedge clock) begin
    ulpi_q <= ulpi_bus_i;
    dir_q  <= ulpi_q.dir;
  end

  // dir_q keeps the turnaround cycle from starting a packet
  assign pid_w    = !in_pkt_q && dir_q && ulpi_q.dir && ulpi_q.nxt;
  assign byte_w   = in_pkt_q && ulpi_q.dir && ulpi_q.nxt;
  assign pid_ok_w = ulpi_q.data[3:0] == ~ulpi_q.data[7:4];

  // RX_CMD without RxActive, or the bus handed back, closes the packet
  assign eop_w = in_pkt_q &&
                 (!ulpi_q.dir || (!ulpi_q.nxt && ulpi_q.data[5:4] != RXCMD_ACTIVE));
  assign rxerr_w = in_pkt_q && ulpi_q.dir && !ulpi_q.nxt &&
                   ulpi_q.data[5:4] == RXCMD_ERROR;

  always_ff @(posedge clock) begin
    if (reset) begin
      in_pkt_q <= 1'b0;
      rx_err_q <= 1'b0;
      nbytes_q <= 2'd0;
    end else begin
      if (pid_w) begin
        in_pkt_q <= 1'b1;
        rx_err_q <= 1'b0;
        nbytes_q <= 2'd0;
      end else if (eop_w) begin
        in_pkt_q <= 1'b0;
        rx_err_q <= rxerr_w;
      end else if (byte_w && nbytes_q != 2'd3) begin
        // Saturates, only 0 to 2 matter for tokens
        nbytes_q <= nbytes_q + 2'd1;
      end
    end
  end

  // CRC16 runs over every byte after the PID
  always_ff @(posedge clock) begin
    if (pid_w) begin
      crc16_q <= 16'hffff;
    end else if (byte_w) begin
      crc16_q <= crc16(ulpi_q.data, crc16_q);
      case (nbytes_q)
        2'd0: begin
          token_q[7:0] <= ulpi_q.data;
        end
        2'd1: begin
          token_q[10:8] <= ulpi_q.data[2:0];
          crc5_q        <= ulpi_q.data[7:3];
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pid_stb_q  <= 1'b0;
      byte_stb_q <= 1'b0;
      eop_stb_q  <= 1'b0;
    end else begin
      pid_stb_q  <= pid_w;
      byte_stb_q <= byte_w;
      eop_stb_q  <= eop_w;
    end
  end

  always_ff @(posedge clock) begin
    pid_q    <= ulpi_q.data[3:0];
    pid_ok_q <= pid_ok_w;
    byte_q   <= ulpi_q.data;
  end

  // PING is framed like a token
  assign is_tok_w = pid_q[1:0] == PID_TOKEN || pid_q == {SPC_PING, PID_SPECIAL};
  assign is_hsk_w = pid_q[1:0] == PID_HANDSHAKE;
  assign is_dat_w = pid_q[1:0] == PID_DATA;

  assign tok_crc_ok_w = nbytes_q == 2'd2 && !rx_err_q && crc5(token_q) == crc5_q;
  assign crc_bad_w    = kind_tok_q ? !tok_crc_ok_w :
                        (rx_err_q || crc16_q != CRC16_RESIDUAL);

  // Other special PIDs and broken PIDs leave the FSM idle
  assign start_w = state_q == RX_IDLE && pid_stb_q && pid_ok_q &&
                   (is_tok_w || is_hsk_w || is_dat_w);
  assign push_w  = (state_q == RX_PID || state_q == RX_DATA) && byte_stb_q;

  // A data byte goes out once two more bytes have arrived behind it
  assign emit_byte_w = push_w && kind_dat_q && hold_cnt_q == 2'd2;
  assign emit_last_w = state_q == RX_LAST && !kind_tok_q;
  assign check_w     = state_q == RX_LAST && (kind_tok_q || kind_dat_q);

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q     <= RX_IDLE;
      hold_cnt_q  <= 2'd0;
      pkt_vld_q   <= 1'b0;
      tok_vld_q   <= 1'b0;
      crc_valid_o <= 1'b0;
      crc_error_o <= 1'b0;
    end else begin
      pkt_vld_q   <= emit_byte_w || emit_last_w;
      tok_vld_q   <= state_q == RX_LAST && kind_tok_q;
      crc_valid_o <= check_w;
      if (check_w) begin
        crc_error_o <= crc_bad_w;
      end

      if (start_w) begin
        hold_cnt_q <= 2'd0;
      end else if (push_w && kind_dat_q && hold_cnt_q != 2'd2) begin
        hold_cnt_q <= hold_cnt_q + 2'd1;
      end

      case (state_q)
        RX_IDLE: begin
          if (start_w) begin
            state_q <= RX_PID;
          end
        end
        RX_PID, RX_DATA: begin
          if (eop_stb_q) begin
            state_q <= RX_LAST;
          end else if (byte_stb_q) begin
            state_q <= RX_DATA;
          end
        end
        RX_LAST: begin
          state_q <= RX_DONE;
        end
        default: begin
          state_q <= RX_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (start_w) begin
      cur_pid_q  <= pid_q;
      kind_tok_q <= is_tok_w;
      kind_dat_q <= is_dat_w;
    end
    if (push_w) begin
      hold0_q <= byte_q;
      hold1_q <= hold0_q;
    end
    if (emit_byte_w) begin
      pkt_data_q <= hold1_q;
      pkt_last_q <= 1'b0;
    end else if (emit_last_w) begin
      pkt_last_q <= 1'b1;
    end
    if (state_q == RX_LAST) begin
      tok_ok_q <= tok_crc_ok_w;
    end
  end

  // Closing beats and handshakes carry no payload, so keep is the inverse of last
  assign pkt_o = '{
    valid: pkt_vld_q,
    keep:  ~pkt_last_q,
    last:  pkt_last_q,
    pid:   cur_pid_q,
    data:  pkt_data_q
  };

  assign tok_o = '{valid: tok_vld_q, crc_ok: tok_ok_q, pid: cur_pid_q, payload: token_q};

endmodule

// File: verilog.f
+incdir+common
common/ulpi_pkg.sv
common/usb_pkg.sv
ulpi_decoder/ulpi_decoder.sv
logic/usb_token_filter.sv
logic/usb_rx_top.sv
bench/usb_rx_tb.sv
